// ==== logic/shift_pkg.sv ====
// No register renaming: rd pending bits are architectural, so WAW/WAR pairs must not share the buffer.
`default_nettype none

package shift_pkg;

	// ============================================================
	// Sizes
	// ============================================================

	localparam int xlen        = 64;
	localparam int half_w      = 32;
	localparam int reg_count   = 32;
	localparam int reg_idx_w   = $clog2(reg_count);
	localparam int issue_depth = 4;
	localparam int slot_idx_w  = $clog2(issue_depth);

	// Six bits of shift amount cover 64-bit shifts; W forms use the low five.
	localparam int shamt_w     = 6;

	// ============================================================
	// Micro-op encoding
	// ============================================================

	// Code 3 is not produced by dispatch.
	typedef enum logic [1:0] {
		sll = 2'd0,
		srl = 2'd1,
		sra = 2'd2
	} shift_op_e;

	typedef struct packed {
		logic                 spare;
		logic [reg_idx_w-1:0] idx;
	} shift_rs2_t;

	// The second source is an immediate amount or an rs2 index, selected by is_imm.
	typedef union packed {
		logic [shamt_w-1:0] imm_shamt;
		shift_rs2_t         rs2;
	} shift_src2_u;

	typedef struct packed {
		shift_op_e            op;
		logic                 is_imm;
		logic                 is32;
		logic [reg_idx_w-1:0] rd;
		logic [reg_idx_w-1:0] rs1;
		shift_src2_u          src2;
	} shift_info_t;

	// Only the low shamt_w bits of op2 reach the shifter.
	typedef struct packed {
		shift_op_e            op;
		logic                 is32;
		logic [reg_idx_w-1:0] rd;
		logic [xlen-1:0]      op1;
		logic [xlen-1:0]      op2;
	} shift_exeparam_t;

	typedef struct packed {
		logic                 valid;
		logic [reg_idx_w-1:0] rd;
		logic [xlen-1:0]      data;
	} wb_t;

endpackage

`default_nettype wire

// ==== logic/shift_issue_buffer.sv ====
// Dispatch while buffer_full is high is dropped; a slot popped this cycle is reusable next cycle.
`default_nettype none
`timescale 1ns/1ps

module shift_issue_buffer (
	input  logic                                           CLK,
	input  logic                                           rst_n,
	input  logic                                           dispatch_valid,
	input  shift_pkg::shift_info_t                         dispatch_info,
	input  logic                                           pop,
	input  logic [shift_pkg::slot_idx_w-1:0]               pop_index,
	output logic                                           buffer_full,
	output logic                                           dispatch_accept,
	output logic [shift_pkg::issue_depth-1:0]              slot_alloc,
	output shift_pkg::shift_info_t [shift_pkg::issue_depth-1:0] slot_info
);

	import shift_pkg::*;

	logic [issue_depth-1:0]  alloc_q;
	logic [issue_depth-1:0]  alloc_set;
	logic [issue_depth-1:0]  alloc_clr;
	logic [slot_idx_w-1:0]   free_index;
	shift_info_t [issue_depth-1:0] info_q;

	assign buffer_full     = &alloc_q;
	assign dispatch_accept = dispatch_valid && !buffer_full;
	assign slot_alloc      = alloc_q;
	assign slot_info       = info_q;

	// Scan downwards so the last hit is the lowest free slot.
	always_comb begin
		free_index = '0;
		for (int i = issue_depth - 1; i >= 0; i--) begin
			if (!alloc_q[i]) begin
				free_index = slot_idx_w'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < issue_depth; i++) begin
			alloc_set[i] = dispatch_accept && (free_index == slot_idx_w'(i));
			alloc_clr[i] = pop && (pop_index == slot_idx_w'(i));
		end
	end

	// The free slot is never the popped one, so set and clear cannot collide.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			alloc_q <= '0;
		end else begin
			alloc_q <= (alloc_q & ~alloc_clr) | alloc_set;
		end
	end

	always_ff @(posedge CLK) begin
		for (int i = 0; i < issue_depth; i++) begin
			if (alloc_set[i]) begin
				info_q[i] <= dispatch_info;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/shift_issue.sv ====
// Execute is always ready, so the selected slot pops unconditionally; there is no operand forwarding.
`default_nettype none
`timescale 1ns/1ps

module shift_issue (
	input  logic                                               CLK,
	input  logic                                               rst_n,
	input  logic [shift_pkg::issue_depth-1:0]                  slot_alloc,
	input  shift_pkg::shift_info_t [shift_pkg::issue_depth-1:0] slot_info,
	input  logic [shift_pkg::reg_count-1:0]                    reg_pending,
	input  logic [shift_pkg::reg_count-1:0][shift_pkg::xlen-1:0] reg_data,
	output logic                                               pop,
	output logic [shift_pkg::slot_idx_w-1:0]                   pop_index,
	output logic                                               exeparam_valid,
	output shift_pkg::shift_exeparam_t                         exeparam
);

	import shift_pkg::*;

	logic [issue_depth-1:0] rs1_ready;
	logic [issue_depth-1:0] rs2_ready;
	logic [issue_depth-1:0] slot_ready;
	logic [slot_idx_w-1:0]  sel_index;
	logic                   any_ready;
	shift_info_t            sel_info;
	logic [xlen-1:0]        sel_op1;
	logic [xlen-1:0]        sel_op2;
	shift_exeparam_t        exeparam_d;
	shift_exeparam_t        exeparam_q;
	logic                   exeparam_valid_q;

	// ============================================================
	// Wakeup and ready check
	// ============================================================

	// The rs2 view is read for every slot; is_imm masks it out where src2 is an immediate.
	always_comb begin
		for (int i = 0; i < issue_depth; i++) begin
			rs1_ready[i]  = !reg_pending[slot_info[i].rs1];
			rs2_ready[i]  = !reg_pending[slot_info[i].src2.rs2.idx];
			slot_ready[i] = slot_alloc[i] && rs1_ready[i]
				&& (slot_info[i].is_imm || rs2_ready[i]);
		end
	end

	// ============================================================
	// Select
	// ============================================================

	// Lowest ready index wins.
	always_comb begin
		sel_index = '0;
		for (int i = issue_depth - 1; i >= 0; i--) begin
			if (slot_ready[i]) begin
				sel_index = slot_idx_w'(i);
			end
		end
	end

	assign any_ready = |slot_ready;
	assign pop       = any_ready;
	assign pop_index = sel_index;

	// ============================================================
	// Operand read
	// ============================================================

	assign sel_info = slot_info[sel_index];
	assign sel_op1  = reg_data[sel_info.rs1];

	always_comb begin
		if (sel_info.is_imm) begin
			sel_op2 = {{(xlen - shamt_w){1'b0}}, sel_info.src2.imm_shamt};
		end else begin
			sel_op2 = reg_data[sel_info.src2.rs2.idx];
		end
	end

	always_comb begin
		exeparam_d.op   = sel_info.op;
		exeparam_d.is32 = sel_info.is32;
		exeparam_d.rd   = sel_info.rd;
		exeparam_d.op1  = sel_op1;
		exeparam_d.op2  = sel_op2;
	end

	// ============================================================
	// Execute parameter register
	// ============================================================

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			exeparam_valid_q <= 1'b0;
		end else begin
			exeparam_valid_q <= any_ready;
		end
	end

	// Hold the last word when nothing issues.
	always_ff @(posedge CLK) begin
		if (any_ready) begin
			exeparam_q <= exeparam_d;
		end
	end

	assign exeparam_valid = exeparam_valid_q;
	assign exeparam       = exeparam_q;

endmodule

`default_nettype wire

// ==== logic/shift_execute.sv ====
// Single-cycle shifter; op code 3 yields zero, and W results are sign-extended from bit 31.
`default_nettype none
`timescale 1ns/1ps

module shift_execute (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic                       exeparam_valid,
	input  shift_pkg::shift_exeparam_t exeparam,
	output shift_pkg::wb_t             wb
);

	import shift_pkg::*;

	logic [shamt_w-1:0]   sh64;
	logic [shamt_w-2:0]   sh32;
	logic [half_w-1:0]    word_in;
	logic [half_w-1:0]    word_res;
	logic [xlen-1:0]      wide_res;
	logic [xlen-1:0]      result;
	logic                 wb_valid_q;
	logic [reg_idx_w-1:0] wb_rd_q;
	logic [xlen-1:0]      wb_data_q;

	assign sh64    = exeparam.op2[shamt_w-1:0];
	assign sh32    = exeparam.op2[shamt_w-2:0];
	assign word_in = exeparam.op1[half_w-1:0];

	// Both widths are computed; is32 picks one.
	always_comb begin
		case (exeparam.op)
			sll: begin
				wide_res = exeparam.op1 << sh64;
				word_res = word_in << sh32;
			end
			srl: begin
				wide_res = exeparam.op1 >> sh64;
				word_res = word_in >> sh32;
			end
			sra: begin
				wide_res = $signed(exeparam.op1) >>> sh64;
				word_res = $signed(word_in) >>> sh32;
			end
			default: begin
				wide_res = '0;
				word_res = '0;
			end
		endcase
	end

	assign result = exeparam.is32 ? {{(xlen - half_w){word_res[half_w-1]}}, word_res} : wide_res;

	// ============================================================
	// Writeback register
	// ============================================================

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= exeparam_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exeparam_valid) begin
			wb_rd_q   <= exeparam.rd;
			wb_data_q <= result;
		end
	end

	always_comb begin
		wb.valid = wb_valid_q;
		wb.rd    = wb_rd_q;
		wb.data  = wb_data_q;
	end

endmodule

`default_nettype wire

// ==== logic/shift_reg_file.sv ====
// x0 reads zero and is never pending; writeback and external write must not target one register together.
`default_nettype none
`timescale 1ns/1ps

module shift_reg_file (
	input  logic                                             CLK,
	input  logic                                             rst_n,
	input  logic                                             dispatch_valid,
	input  logic [shift_pkg::reg_idx_w-1:0]                  dispatch_rd,
	input  logic                                             dispatch_accept,
	input  shift_pkg::wb_t                                   wb,
	input  logic                                             ext_wr_valid,
	input  logic [shift_pkg::reg_idx_w-1:0]                  ext_wr_rd,
	input  logic [shift_pkg::xlen-1:0]                       ext_wr_data,
	output logic [shift_pkg::reg_count-1:0]                  reg_pending,
	output logic [shift_pkg::reg_count-1:0][shift_pkg::xlen-1:0] reg_data
);

	import shift_pkg::*;

	logic [reg_count-1:0][xlen-1:0] regs_q;
	logic [reg_count-1:0]           pending_q;
	logic [reg_count-1:0]           wb_hit;
	logic [reg_count-1:0]           ext_hit;
	logic [reg_count-1:0]           pend_set;
	logic [reg_count-1:0]           pend_clr;

	// Decode both write ports and the dispatch rd; bit 0 stays clear in all masks.
	always_comb begin
		for (int i = 0; i < reg_count; i++) begin
			wb_hit[i]   = (i != 0) && wb.valid && (wb.rd == reg_idx_w'(i));
			ext_hit[i]  = (i != 0) && ext_wr_valid && (ext_wr_rd == reg_idx_w'(i));
			pend_set[i] = (i != 0) && dispatch_valid && dispatch_accept
				&& (dispatch_rd == reg_idx_w'(i));
		end
	end

	assign pend_clr = wb_hit | ext_hit;

	// ============================================================
	// Register contents
	// ============================================================

	// The writeback port wins over the external port.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			regs_q <= '0;
		end else begin
			for (int i = 1; i < reg_count; i++) begin
				if (wb_hit[i]) begin
					regs_q[i] <= wb.data;
				end else if (ext_hit[i]) begin
					regs_q[i] <= ext_wr_data;
				end
			end
		end
	end

	// ============================================================
	// Pending scoreboard
	// ============================================================

	// A new dispatch to rd outranks a write retiring the older producer.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pending_q <= '0;
		end else begin
			pending_q <= (pending_q & ~pend_clr) | pend_set;
		end
	end

	assign reg_pending = pending_q;
	assign reg_data    = regs_q;

endmodule

`default_nettype wire

// ==== logic/shift_unit_top.sv ====
// Dispatch has no handshake beyond buffer_full; results appear on wb two edges after selection.
`default_nettype none
`timescale 1ns/1ps

module shift_unit_top (
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic                          dispatch_valid,
	input  shift_pkg::shift_info_t        dispatch_info,
	output logic                          buffer_full,
	input  logic                          ext_wr_valid,
	input  logic [shift_pkg::reg_idx_w-1:0] ext_wr_rd,
	input  logic [shift_pkg::xlen-1:0]    ext_wr_data,
	output shift_pkg::wb_t                wb
);

	import shift_pkg::*;

	logic                                  dispatch_accept;
	logic                                  pop;
	logic [slot_idx_w-1:0]                 pop_index;
	logic [issue_depth-1:0]                slot_alloc;
	shift_info_t [issue_depth-1:0]         slot_info;
	logic [reg_count-1:0]                  reg_pending;
	logic [reg_count-1:0][xlen-1:0]        reg_data;
	logic                                  exeparam_valid;
	shift_exeparam_t                       exeparam;

	shift_issue_buffer shift_issue_buffer_inst (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.dispatch_valid  (dispatch_valid),
		.dispatch_info   (dispatch_info),
		.pop             (pop),
		.pop_index       (pop_index),
		.buffer_full     (buffer_full),
		.dispatch_accept (dispatch_accept),
		.slot_alloc      (slot_alloc),
		.slot_info       (slot_info)
	);

	shift_issue shift_issue_inst (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.slot_alloc     (slot_alloc),
		.slot_info      (slot_info),
		.reg_pending    (reg_pending),
		.reg_data       (reg_data),
		.pop            (pop),
		.pop_index      (pop_index),
		.exeparam_valid (exeparam_valid),
		.exeparam       (exeparam)
	);

	shift_execute shift_execute_inst (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.exeparam_valid (exeparam_valid),
		.exeparam       (exeparam),
		.wb             (wb)
	);

	// Pending is marked with the same accept that stores the slot.
	shift_reg_file shift_reg_file_inst (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.dispatch_valid  (dispatch_valid),
		.dispatch_rd     (dispatch_info.rd),
		.dispatch_accept (dispatch_accept),
		.wb              (wb),
		.ext_wr_valid    (ext_wr_valid),
		.ext_wr_rd       (ext_wr_rd),
		.ext_wr_data     (ext_wr_data),
		.reg_pending     (reg_pending),
		.reg_data        (reg_data)
	);

endmodule

`default_nettype wire

// ==== test/shift_unit_ref.svh ====
// Included inside the testbench module after the shift_pkg import; the mirror assumes no WAW or WAR pairs in flight.
`ifndef SHIFT_UNIT_REF_SVH
`define SHIFT_UNIT_REF_SVH

	// Architectural register values as the testbench expects them in program order.
	logic [xlen-1:0] mirror_regs [reg_count] = '{default: '0};

	function automatic logic [xlen-1:0] mirror_read(input logic [reg_idx_w-1:0] idx);
		if (idx == '0) begin
			return '0;
		end
		return mirror_regs[idx];
	endfunction

	function automatic void mirror_write(input logic [reg_idx_w-1:0] idx,
			input logic [xlen-1:0] value);
		if (idx != '0) begin
			mirror_regs[idx] = value;
		end
	endfunction

	// Bit by bit shift over a 32- or 64-bit window, the W forms sign-extended from bit 31.
	function automatic logic [xlen-1:0] ref_shift(input shift_op_e op, input logic is32,
			input logic [xlen-1:0] op1, input logic [xlen-1:0] op2);
		logic [xlen-1:0] res;
		logic            fill;
		int              width;
		int              amt;
		res = '0;
		width = is32 ? 32 : 64;
		amt = is32 ? int'(op2[4:0]) : int'(op2[5:0]);
		fill = (op == sra) ? op1[6'(width - 1)] : 1'b0;
		for (int b = 0; b < width; b++) begin
			case (op)
				sll: res[6'(b)] = (b >= amt) ? op1[6'(b - amt)] : 1'b0;
				srl, sra: res[6'(b)] = (b + amt < width) ? op1[6'(b + amt)] : fill;
				default: res[6'(b)] = 1'b0;
			endcase
		end
		if (is32) begin
			res[xlen-1:32] = {32{res[31]}};
		end
		return res;
	endfunction

`endif

// ==== test/shift_unit_tb.sv ====
// Results are matched by rd, so the testbench keeps at most one result per rd in flight.
`default_nettype none
`timescale 1ns/1ps

module shift_unit_tb;

	import shift_pkg::*;

	`include "shift_unit_ref.svh"

	localparam int drain_limit = 60;

	logic        CLK;
	logic        rst_n;
	logic        dispatch_valid;
	shift_info_t dispatch_info;
	logic        buffer_full;
	logic        ext_wr_valid;
	logic [reg_idx_w-1:0] ext_wr_rd;
	logic [xlen-1:0]      ext_wr_data;
	wb_t         wb;

	wb_t   exp_q[$];
	string exp_name[$];
	int    wb_cycle [reg_count];
	int    cycle_count = 0;
	int    check_count = 0;
	int    error_count = 0;
	int    test_base   = 0;
	int    seed        = 32'h7c2f_7f45;

	shift_unit_top shift_unit_top_inst (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_info  (dispatch_info),
		.buffer_full    (buffer_full),
		.ext_wr_valid   (ext_wr_valid),
		.ext_wr_rd      (ext_wr_rd),
		.ext_wr_data    (ext_wr_data),
		.wb             (wb)
	);

	always #50 CLK = ~CLK;

	// ============================================================
	// Compare tasks and drivers
	// ============================================================

	task automatic check_wb(input string name, input wb_t exp, input wb_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[ERROR] %s: expected rd x%0d data %h, actual rd x%0d data %h",
				name, exp.rd, exp.data, act.rd, act.data);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	function automatic shift_info_t make_info(input shift_op_e op, input logic is_imm,
			input logic is32, input logic [reg_idx_w-1:0] rd,
			input logic [reg_idx_w-1:0] rs1, input logic [shamt_w-1:0] src2_bits);
		shift_info_t info;
		info.op = op;
		info.is_imm = is_imm;
		info.is32 = is32;
		info.rd = rd;
		info.rs1 = rs1;
		info.src2.imm_shamt = src2_bits;
		return info;
	endfunction

	task automatic dispatch_op(input shift_info_t info);
		@(negedge CLK);
		if (buffer_full) begin
			error_count++;
			$display("Dispatch to x%0d attempted while the buffer was full", info.rd);
		end
		ext_wr_valid = 1'b0;
		dispatch_valid = 1'b1;
		dispatch_info = info;
	endtask

	task automatic ext_write(input logic [reg_idx_w-1:0] rd, input logic [xlen-1:0] data);
		@(negedge CLK);
		dispatch_valid = 1'b0;
		ext_wr_valid = 1'b1;
		ext_wr_rd = rd;
		ext_wr_data = data;
		mirror_write(rd, data);
	endtask

	task automatic idle_cycle();
		@(negedge CLK);
		dispatch_valid = 1'b0;
		ext_wr_valid = 1'b0;
	endtask

	// The expected value is taken from the mirror when the operands are final.
	task automatic expect_op(input shift_info_t info, input string name);
		logic [xlen-1:0] op1;
		logic [xlen-1:0] op2;
		wb_t             exp;
		op1 = mirror_read(info.rs1);
		if (info.is_imm) begin
			op2 = {{(xlen - shamt_w){1'b0}}, info.src2.imm_shamt};
		end else begin
			op2 = mirror_read(info.src2.rs2.idx);
		end
		exp.valid = 1'b1;
		exp.rd = info.rd;
		exp.data = ref_shift(info.op, info.is32, op1, op2);
		exp_q.push_back(exp);
		exp_name.push_back(name);
		mirror_write(info.rd, exp.data);
	endtask

	task automatic wait_drain(input string name);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < drain_limit) begin
			@(negedge CLK);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%s: timed out with %0d results never written back", name, exp_q.size());
			error_count += exp_q.size();
			exp_q.delete();
			exp_name.delete();
		end
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d errors", name, error_count - test_base);
		test_base = error_count;
	endtask

	// wb is registered, so the falling edge sees it settled.
	always @(negedge CLK) begin : compare_wb
		int hit;
		hit = -1;
		cycle_count++;
		if (rst_n && wb.valid) begin
			for (int i = 0; i < exp_q.size(); i++) begin
				if (hit < 0 && exp_q[i].rd == wb.rd) begin
					hit = i;
				end
			end
			if (hit < 0) begin
				error_count++;
				$display("Unexpected writeback to x%0d with data %h", wb.rd, wb.data);
			end else begin
				check_wb(exp_name[hit], exp_q[hit], wb);
				exp_q.delete(hit);
				exp_name.delete(hit);
				wb_cycle[wb.rd] = cycle_count;
			end
		end
	end

	// ============================================================
	// Tests
	// ============================================================

	task automatic run_reset_idle();
		shift_info_t info;
		for (int i = 0; i < 4; i++) begin
			@(negedge CLK);
			check_flag("t1 wb idle after reset", 1'b0, wb.valid);
			check_flag("t1 buffer_full after reset", 1'b0, buffer_full);
		end
		info = make_info(sll, 1'b1, 1'b0, 5'd5, 5'd0, 6'd7);
		dispatch_op(info);
		expect_op(info, "t1 slli x5, x0, 7");
		idle_cycle();
		check_flag("t1 wb early after dispatch", 1'b0, wb.valid);
		@(negedge CLK);
		check_flag("t1 wb early after select", 1'b0, wb.valid);
		@(negedge CLK);
		check_flag("t1 wb two edges after select", 1'b1, wb.valid);
		wait_drain("t1");
		report_test("test 1 reset and x0 shift");
	endtask

	task automatic run_random();
		shift_info_t     info;
		logic [xlen-1:0] v;
		int              pick;
		logic [reg_idx_w-1:0] rs1;
		logic [reg_idx_w-1:0] rs2;
		for (int r = 1; r <= 8; r++) begin
			v[63:32] = $random(seed);
			v[31:0] = $random(seed);
			ext_write(reg_idx_w'(r), v);
		end
		for (int i = 0; i < 12; i++) begin
			pick = $random(seed);
			rs1 = reg_idx_w'(1 + (pick & 7));
			rs2 = reg_idx_w'(1 + ((pick >> 4) & 7));
			if ((i / 3) % 2 == 0) begin
				info = make_info(shift_op_e'(i % 3), 1'b1, 1'b0, reg_idx_w'(9 + i), rs1,
					shamt_w'($random(seed)));
			end else begin
				info = make_info(shift_op_e'(i % 3), 1'b0, 1'b0, reg_idx_w'(9 + i), rs1,
					{1'b0, rs2});
			end
			dispatch_op(info);
			expect_op(info, $sformatf("t2 op %0d", i));
		end
		idle_cycle();
		wait_drain("t2");
		report_test("test 2 random 64-bit shifts");
	endtask

	task automatic run_word();
		shift_info_t     info;
		logic [xlen-1:0] v;
		v[63:32] = $random(seed);
		v[31:0] = $random(seed);
		ext_write(5'd1, v | 64'h8000_0000);
		ext_write(5'd2, v & ~64'h8000_0000);
		ext_write(5'd3, {v[31:0], v[63:32]});
		for (int i = 0; i < 6; i++) begin
			if (i % 2 == 0) begin
				info = make_info(shift_op_e'(i % 3), 1'b1, 1'b1, reg_idx_w'(21 + i),
					(i < 3) ? 5'd1 : 5'd2, shamt_w'($random(seed)));
			end else begin
				info = make_info(shift_op_e'(i % 3), 1'b0, 1'b1, reg_idx_w'(21 + i),
					(i < 3) ? 5'd1 : 5'd2, 6'd3);
			end
			dispatch_op(info);
			expect_op(info, $sformatf("t3 word op %0d", i));
		end
		idle_cycle();
		wait_drain("t3");
		report_test("test 3 word shifts");
	endtask

	// x10 waits on x13, so both consumers are buffered while x10 is still pending.
	// A consumer writes back no earlier than three edges after its producer.
	task automatic run_dependence();
		shift_info_t info;
		info = make_info(sll, 1'b1, 1'b0, 5'd13, 5'd1, shamt_w'($random(seed)));
		dispatch_op(info);
		expect_op(info, "t4 producer x13");
		info = make_info(sll, 1'b1, 1'b0, 5'd10, 5'd13, shamt_w'($random(seed)));
		dispatch_op(info);
		expect_op(info, "t4 producer x10");
		info = make_info(srl, 1'b1, 1'b0, 5'd11, 5'd10, shamt_w'($random(seed)));
		dispatch_op(info);
		expect_op(info, "t4 consumer x11");
		info = make_info(sra, 1'b0, 1'b0, 5'd12, 5'd2, {1'b0, 5'd10});
		dispatch_op(info);
		expect_op(info, "t4 consumer x12");
		idle_cycle();
		wait_drain("t4");
		check_flag("t4 x10 after x13 result", 1'b1, wb_cycle[10] >= wb_cycle[13] + 3);
		check_flag("t4 x11 after x10 result", 1'b1, wb_cycle[11] >= wb_cycle[10] + 3);
		check_flag("t4 x12 after x10 result", 1'b1, wb_cycle[12] >= wb_cycle[10] + 3);
		report_test("test 4 dependence");
	endtask

	// Each op reads its own rd, so it waits until the external port writes that register.
	task automatic run_stall();
		shift_info_t     info [4];
		logic [xlen-1:0] v;
		for (int i = 0; i < 4; i++) begin
			info[i] = make_info(shift_op_e'(i % 3), 1'b1, logic'(i == 3),
				reg_idx_w'(27 + i), reg_idx_w'(27 + i), shamt_w'($random(seed)));
			dispatch_op(info[i]);
		end
		idle_cycle();
		check_flag("t5 buffer_full with four stalled", 1'b1, buffer_full);
		for (int i = 0; i < 3; i++) begin
			@(negedge CLK);
			check_flag("t5 no writeback while stalled", 1'b0, wb.valid);
		end
		for (int i = 3; i >= 0; i--) begin
			v[63:32] = $random(seed);
			v[31:0] = $random(seed);
			ext_write(info[i].rs1, v);
			expect_op(info[i], $sformatf("t5 released x%0d", info[i].rd));
		end
		idle_cycle();
		wait_drain("t5");
		check_flag("t5 buffer_full after drain", 1'b0, buffer_full);
		report_test("test 5 full buffer release");
	endtask

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_info = '0;
		ext_wr_valid = 1'b0;
		ext_wr_rd = '0;
		ext_wr_data = '0;
		repeat (8) @(negedge CLK);
		rst_n = 1'b1;
		run_reset_idle();
		run_random();
		run_word();
		run_dependence();
		run_stall();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+test
logic/shift_pkg.sv
logic/shift_issue_buffer.sv
logic/shift_issue.sv
logic/shift_execute.sv
logic/shift_reg_file.sv
logic/shift_unit_top.sv
test/shift_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the shift unit testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -f sim.f --top-module shift_unit_tb -Mdir obj_dir \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/Vshift_unit_tb > sim.log 2>&1

grep -qx "All checks passed" sim.log \
	&& { echo "Simulation passed, see sim.log"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
